//--- include/fpadd_consts.svh
// Binary32 field widths and encoding constants for the floating-point adder
`ifndef FPADD_CONSTS_SVH
`define FPADD_CONSTS_SVH

// Field widths of the packed word
`define FP_EXP_WIDTH 8
`define FP_MANT_WIDTH 23

// Exponent bias of binary32
`define FP_BIAS 127

// All-ones exponent shared by infinity and NaN
`define FP_EXP_MAX 255

// Canonical quiet NaN returned for every invalid case
`define FP_QNAN 32'h7FC00000

// Hidden bit, fraction, then guard, round and sticky
`define FP_EXT_WIDTH 27

`endif

//--- src/fpAddPkg.sv
// Shared types for the pipelined binary32 adder: opcodes, operand classes, stage payloads
`default_nettype none

`include "fpadd_consts.svh"

package fpAddPkg;

    typedef enum logic
    {
        opAdd = 1'b0,
        opSub = 1'b1
    } fpOp_t;

    // Subnormals are reported as classZero
    typedef enum logic [1:0]
    {
        classZero   = 2'd0,
        classNormal = 2'd1,
        classInf    = 2'd2,
        classNan    = 2'd3
    } fpClass_t;

    // Output of the alignment stage
    typedef struct packed
    {
        logic                        signA;
        logic                        signB;
        logic [`FP_EXP_WIDTH-1:0]    exponent;
        logic [`FP_EXT_WIDTH-1:0]    mantA;
        logic [`FP_EXT_WIDTH-1:0]    mantB;
        fpClass_t                    special;
        logic                        specialSign;
    } alignedOps_t;

    // Output of the mantissa adder, one carry bit above the extended width
    typedef struct packed
    {
        logic                        sign;
        logic [`FP_EXP_WIDTH-1:0]    exponent;
        logic [`FP_EXT_WIDTH:0]      magnitude;
        fpClass_t                    special;
        logic                        bothNegZero;
    } rawSum_t;

endpackage

`default_nettype wire

//--- src/alignment.sv
// Alignment stage: classifies both operands and right-shifts the smaller one with GRS bits
`timescale 1ns/1ps
`default_nettype none

`include "fpadd_consts.svh"

module alignment import fpAddPkg::*;
(
    input  logic [31:0] opA,
    input  logic [31:0] opB,
    input  fpOp_t       op,
    output alignedOps_t aligned
);

    logic                      signA, signB;
    logic [`FP_EXP_WIDTH-1:0]  expA, expB;
    logic [`FP_MANT_WIDTH-1:0] fracA, fracB;
    fpClass_t                  classA, classB;
    logic [`FP_EXT_WIDTH-1:0]  extA, extB;
    logic                      swap;
    logic [`FP_EXP_WIDTH-1:0]  expDiff;
    logic [23:0]               shiftSrc;
    logic [49:0]               shiftWide;
    logic [`FP_EXT_WIDTH-1:0]  shiftedExt;

    function automatic fpClass_t classify(input logic [7:0] e, input logic [22:0] f);
        if (e == `FP_EXP_MAX)
            return (f != '0) ? classNan : classInf;
        else if (e == '0)
            return classZero;
        else
            return classNormal;
    endfunction

    // Field split, subtract flips the sign of B
    assign signA = opA[31];
    assign expA = opA[30:23];
    assign fracA = opA[22:0];
    assign signB = opB[31] ^ (op == opSub);
    assign expB = opB[30:23];
    assign fracB = opB[22:0];

    assign classA = classify(expA, fracA);
    assign classB = classify(expB, fracB);

    // Zero and subnormal operands contribute no magnitude
    assign extA = (classA == classNormal) ? {1'b1, fracA, 3'b000} : '0;
    assign extB = (classB == classNormal) ? {1'b1, fracB, 3'b000} : '0;

    // Single shifter on whichever operand has the smaller exponent
    assign swap = expB > expA;
    assign expDiff = swap ? (expB - expA) : (expA - expB);
    assign shiftSrc = swap ? {1'b1, fracA} : {1'b1, fracB};
    assign shiftWide = {shiftSrc, 26'b0} >> expDiff;

    always_comb
    begin
        // Everything past the round position collapses into sticky
        if (expDiff > 8'd26)
            shiftedExt = {26'b0, |shiftSrc};
        else
            shiftedExt = {shiftWide[49:24], |shiftWide[23:0]};
    end

    always_comb
    begin
        aligned.signA = signA;
        aligned.signB = signB;
        aligned.exponent = '0;
        aligned.mantA = '0;
        aligned.mantB = '0;
        aligned.special = classNormal;
        aligned.specialSign = 1'b0;

        if (classA == classNan || classB == classNan)
        begin
            aligned.special = classNan;
        end
        else if (classA == classInf && classB == classInf)
        begin
            // Opposite infinities are invalid
            aligned.special = (signA != signB) ? classNan : classInf;
            aligned.specialSign = signA;
        end
        else if (classA == classInf || classB == classInf)
        begin
            aligned.special = classInf;
            aligned.specialSign = (classA == classInf) ? signA : signB;
        end
        else if (classA == classZero || classB == classZero)
        begin
            // The nonzero operand, if any, stays unshifted
            aligned.exponent = (classA == classZero) ? expB : expA;
            aligned.mantA = extA;
            aligned.mantB = extB;
        end
        else if (swap)
        begin
            aligned.exponent = expB;
            aligned.mantA = shiftedExt;
            aligned.mantB = extB;
        end
        else
        begin
            aligned.exponent = expA;
            aligned.mantA = extA;
            aligned.mantB = shiftedExt;
        end
    end

endmodule

`default_nettype wire

//--- src/mantissaAdder.sv
// Mantissa adder stage: signed-magnitude add or subtract of the aligned extended mantissas
`timescale 1ns/1ps
`default_nettype none

`include "fpadd_consts.svh"

module mantissaAdder import fpAddPkg::*;
(
    input  alignedOps_t aligned,
    output rawSum_t     sum
);

    logic [`FP_EXT_WIDTH:0] magA, magB;
    logic                   sameSign;
    logic                   aNotSmaller;
    logic                   exactZero;

    // One extra bit on top for the carry of an effective add
    assign magA = {1'b0, aligned.mantA};
    assign magB = {1'b0, aligned.mantB};

    assign sameSign = aligned.signA == aligned.signB;
    assign aNotSmaller = aligned.mantA >= aligned.mantB;

    always_comb
    begin
        if (sameSign)
            sum.magnitude = magA + magB;
        else if (aNotSmaller)
            sum.magnitude = magA - magB;
        else
            sum.magnitude = magB - magA;
    end

    assign exactZero = sum.magnitude == '0;

    always_comb
    begin
        // Special results carry the sign decided at alignment
        if (aligned.special != classNormal)
            sum.sign = aligned.specialSign;
        else if (sameSign)
            sum.sign = aligned.signA;
        else if (exactZero)
            sum.sign = 1'b0;
        else
            sum.sign = aNotSmaller ? aligned.signA : aligned.signB;
    end

    assign sum.exponent = aligned.exponent;
    assign sum.special = aligned.special;

    // Only -0 + -0 keeps a negative zero
    assign sum.bothNegZero = aligned.signA & aligned.signB &
                             (aligned.mantA == '0) & (aligned.mantB == '0);

endmodule

`default_nettype wire

//--- src/normalizeRound.sv
// Normalize and round stage: leading-zero shift, round to nearest even, range checks, packing
`timescale 1ns/1ps
`default_nettype none

`include "fpadd_consts.svh"

module normalizeRound import fpAddPkg::*;
(
    input  rawSum_t     sum,
    output logic [31:0] word
);

    logic [4:0]                leadZeros;
    logic [`FP_EXT_WIDTH-1:0]  normMant;
    logic signed [9:0]         baseExp;
    logic signed [9:0]         normExp;
    logic                      roundUp;
    logic [24:0]               rounded;
    logic [`FP_MANT_WIDTH-1:0] fracOut;
    logic signed [9:0]         finalExp;

    assign baseExp = $signed({2'b00, sum.exponent});

    // Leading zero count below the carry bit, highest set bit wins
    always_comb
    begin
        leadZeros = '0;
        for (int i = 0; i < `FP_EXT_WIDTH; i++)
        begin
            if (sum.magnitude[i])
                leadZeros = 5'(`FP_EXT_WIDTH - 1 - i);
        end
    end

    always_comb
    begin
        if (sum.magnitude[`FP_EXT_WIDTH])
        begin
            // Carry out, drop one bit into sticky
            normMant = {sum.magnitude[27:2], sum.magnitude[1] | sum.magnitude[0]};
            normExp = baseExp + 10'sd1;
        end
        else
        begin
            normMant = sum.magnitude[26:0] << leadZeros;
            normExp = baseExp - $signed({5'b00000, leadZeros});
        end
    end

    // Guard decides, round or sticky or an odd LSB breaks the tie upward
    assign roundUp = normMant[2] & (normMant[1] | normMant[0] | normMant[3]);
    assign rounded = {1'b0, normMant[26:3]} + {24'b0, roundUp};

    always_comb
    begin
        if (rounded[24])
        begin
            // Mantissa rolled over to 2.0
            fracOut = rounded[23:1];
            finalExp = normExp + 10'sd1;
        end
        else
        begin
            fracOut = rounded[22:0];
            finalExp = normExp;
        end
    end

    always_comb
    begin
        case (sum.special)
            classNan:
                word = `FP_QNAN;
            classInf:
                word = {sum.sign, 8'hFF, 23'b0};
            classZero:
                word = {sum.sign, 31'b0};
            default:
            begin
                if (sum.magnitude == '0)
                    word = {sum.bothNegZero, 31'b0};
                else if (finalExp >= 10'sd`FP_EXP_MAX)
                    word = {sum.sign, 8'hFF, 23'b0};
                else if (finalExp <= 10'sd0)
                    word = {sum.sign, 31'b0};  // flush, no subnormal results
                else
                    word = {sum.sign, finalExp[7:0], fracOut};
            end
        endcase
    end

endmodule

`default_nettype wire

//--- src/fpAdder.sv
// Three-stage pipelined binary32 adder/subtractor with valid strobes and no back-pressure
`timescale 1ns/1ps
`default_nettype none

module fpAdder import fpAddPkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  logic        inValid,
    input  fpOp_t       op,
    input  logic [31:0] operandA,
    input  logic [31:0] operandB,
    output logic        outValid,
    output logic [31:0] result
);

    alignedOps_t alignedNext;
    alignedOps_t stage1Ops;
    rawSum_t     sumNext;
    rawSum_t     stage2Sum;
    logic [31:0] wordNext;
    logic        stage1Valid;
    logic        stage2Valid;

    // Stage 1 combinational: classify and align
    alignment align_i
    (
        .opA     (operandA),
        .opB     (operandB),
        .op      (op),
        .aligned (alignedNext)
    );

    // Stage 2 combinational: signed mantissa add
    mantissaAdder adder_i
    (
        .aligned (stage1Ops),
        .sum     (sumNext)
    );

    // Stage 3 combinational: normalize, round, pack
    normalizeRound norm_i
    (
        .sum  (stage2Sum),
        .word (wordNext)
    );

    // Valid chain, one bit per register stage
    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            stage1Valid <= 1'b0;
            stage2Valid <= 1'b0;
            outValid <= 1'b0;
        end
        else
        begin
            stage1Valid <= inValid;
            stage2Valid <= stage1Valid;
            outValid <= stage2Valid;
        end
    end

    // Payload registers advance every cycle
    always_ff @(posedge clock)
    begin
        stage1Ops <= alignedNext;
        stage2Sum <= sumNext;
        result <= wordNext;
    end

endmodule

`default_nettype wire

//--- tests/fpAdder_checker.sv
// Pipeline assertions for the binary32 adder: reset quiet window, fixed latency, known results
`timescale 1ns/1ps
`default_nettype none

module fpAdder_checker
(
    input wire logic        clock,
    input wire logic        reset,
    input wire logic        inValid,
    input wire logic        outValid,
    input wire logic [31:0] result
);

    int assertFails = 0;

    // No output strobe while reset is high or in the cycle after it
    quietAfterReset: assert property (@(posedge clock) reset |=> !outValid ##1 !outValid)
    else
    begin
        assertFails++;
        $error("outValid was high during reset or in the cycle after it");
    end

    // Three register stages between the strobes
    fixedLatency: assert property (@(posedge clock) disable iff (reset)
        !$past(reset) && !$past(reset, 2) && !$past(reset, 3) |-> outValid == $past(inValid, 3))
    else
    begin
        assertFails++;
        $error("outValid does not follow inValid after three cycles");
    end

    knownResult: assert property (@(posedge clock) disable iff (reset)
        outValid |-> !$isunknown(result))
    else
    begin
        assertFails++;
        $error("result holds unknown bits while outValid is high");
    end

endmodule

`default_nettype wire

//--- tests/fpAdderMonitor.sv
// Result monitor for the binary32 adder: reference model, expected queue and in-order compare
`timescale 1ns/1ps
`default_nettype none

`include "fpadd_consts.svh"

module fpAdderMonitor import fpAddPkg::*;
(
    input  wire logic        clock,
    input  wire logic        reset,
    input  wire logic        inValid,
    input  wire fpOp_t       op,
    input  wire logic [31:0] operandA,
    input  wire logic [31:0] operandB,
    input  wire logic        outValid,
    input  wire logic [31:0] result,
    output int               pending,
    output int               checkCount,
    output int               failCount
);

    typedef struct packed
    {
        logic [31:0] a;
        logic [31:0] b;
        logic        sub;
        logic [31:0] expected;
    } expEntry_t;

    expEntry_t expQueue[$];
    expEntry_t head;
    int        checks = 0;
    int        fails = 0;
    int        queued = 0;
    logic      resetDly1;
    logic      resetDly2;

    assign pending = queued;
    assign checkCount = checks;
    assign failCount = fails;

    // Right shift that folds every lost bit into bit 0
    function automatic longint shiftSticky(input longint m, input int d);
        if (d >= 27)
            return (m != 0) ? 1 : 0;
        return (m >> d) | (((m & ((64'd1 << d) - 1)) != 0) ? 1 : 0);
    endfunction

    function automatic logic [31:0] fpAddRef(input logic [31:0] a, input logic [31:0] b,
                                             input logic sub);
        logic   sa, sb, sr;
        int     ea, eb, er;
        longint ma, mb, mr, keep;
        sa = a[31];
        sb = b[31] ^ sub;
        ea = a[30:23];
        eb = b[30:23];
        if ((ea == 255 && a[22:0] != 0) || (eb == 255 && b[22:0] != 0))
            return `FP_QNAN;
        if (ea == 255 && eb == 255)
            return (sa != sb) ? `FP_QNAN : {sa, 8'hFF, 23'h0};
        if (ea == 255 || eb == 255)
            return (ea == 255) ? {sa, 8'hFF, 23'h0} : {sb, 8'hFF, 23'h0};
        // Subnormals and zeros carry no magnitude
        if (ea == 0 && eb == 0)
            return {sa & sb, 31'h0};
        ma = (ea == 0) ? 0 : (longint'(a[22:0]) + 64'h80_0000) * 8;
        mb = (eb == 0) ? 0 : (longint'(b[22:0]) + 64'h80_0000) * 8;
        er = (ea >= eb) ? ea : eb;
        if (ea >= eb)
            mb = shiftSticky(mb, ea - eb);
        else
            ma = shiftSticky(ma, eb - ea);
        sr = (ma >= mb) ? sa : sb;
        mr = (sa == sb) ? ma + mb : ((ma >= mb) ? ma - mb : mb - ma);
        if (mr == 0)
            return 32'h0;
        if (mr >= (64'd1 << 27))
        begin
            mr = (mr >> 1) | (mr & 1);
            er++;
        end
        while (mr < (64'd1 << 26))
        begin
            mr = mr << 1;
            er--;
        end
        // Guard decides, a tie goes to the even neighbour
        keep = mr >> 3;
        if (mr[2] && (mr[1:0] != 0 || keep[0]))
            keep++;
        if (keep >= (64'd1 << 24))
        begin
            keep = keep >> 1;
            er++;
        end
        if (er >= 255)
            return {sr, 8'hFF, 23'h0};
        if (er <= 0)
            return {sr, 31'h0};
        return {sr, 8'(er), keep[22:0]};
    endfunction

    always @(posedge clock)
    begin
        if (outValid === 1'b1)
        begin
            if (resetDly1 === 1'b1 || resetDly2 === 1'b1)
            begin
                $display("outValid was high during reset or in the cycle after it");
                fails++;
            end
            else if (expQueue.size() == 0)
            begin
                $display("An output arrived with no operation waiting for it");
                fails++;
            end
            else
            begin
                head = expQueue.pop_front();
                checks++;
                if (result !== head.expected)
                begin
                    $display("[FAIL] result: a=%h b=%h sub=%b expected %h actual %h",
                             head.a, head.b, head.sub, head.expected, result);
                    fails++;
                end
            end
        end
        // Reset drops whatever is still in flight
        if (reset === 1'b1)
            expQueue.delete();
        else if (inValid === 1'b1)
            expQueue.push_back({operandA, operandB, op == opSub,
                                fpAddRef(operandA, operandB, op == opSub)});
        queued = expQueue.size();
        resetDly2 = resetDly1;
        resetDly1 = reset;
    end

endmodule

`default_nettype wire

//--- tests/fpAdderTb.sv
// Testbench top for the pipelined binary32 adder with clock, reset, directed and random tests
`timescale 1ns/1ps
`default_nettype none

module fpAdderTb import fpAddPkg::*;
();

    logic        clock;
    logic        reset;
    logic        inValid;
    fpOp_t       op;
    logic [31:0] operandA;
    logic [31:0] operandB;
    wire logic        outValid;
    wire logic [31:0] result;
    int          pending;
    int          checkCount;
    int          failCount;
    int          sent = 0;
    int          checksAtStart = 0;
    int          failsAtStart = 0;
    int          testPass = 0;
    int          testFail = 0;
    integer      seed = 90038;

    fpAdder dut_i (.*);

    fpAdderMonitor monitor_i (.*);

    bind fpAdder fpAdder_checker checker_i
    (
        .clock    (clock),
        .reset    (reset),
        .inValid  (inValid),
        .outValid (outValid),
        .result   (result)
    );

    initial
    begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    task automatic sendOp(input logic [31:0] a, input logic [31:0] b, input fpOp_t o);
        @(negedge clock);
        inValid = 1'b1;
        operandA = a;
        operandB = b;
        op = o;
        sent++;
    endtask

    // Stops input, waits for the pipeline to drain and prints the test line
    task automatic finishTest(input string name, input bit countOutputs);
        int waited;
        int checked;
        bit failed;
        @(negedge clock);
        inValid = 1'b0;
        waited = 0;
        while (pending != 0 && waited < 20)
        begin
            @(negedge clock);
            waited++;
        end
        checked = checkCount - checksAtStart;
        failed = failCount != failsAtStart;
        if (pending != 0)
        begin
            $display("%s: %0d outputs went missing", name, pending);
            failed = 1'b1;
        end
        if (countOutputs && checked != sent)
        begin
            $display("%s: %0d operations sent but %0d results came out", name, sent, checked);
            failed = 1'b1;
        end
        $display("%s: %0d results checked, %0d failures, %s", name, checked,
                 failCount - failsAtStart, failed ? "failed" : "passed");
        if (failed)
            testFail++;
        else
            testPass++;
        checksAtStart = checkCount;
        failsAtStart = failCount;
        sent = 0;
    endtask

    initial
    begin
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] opBits;
        reset = 1'b1;
        inValid = 1'b0;
        op = opAdd;
        operandA = '0;
        operandB = '0;
        repeat (8) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        sendOp(32'h3F800000, 32'h3F800000, opAdd);
        sendOp(32'h3FC00000, 32'h3FC00000, opAdd);
        sendOp(32'h40490FDB, 32'h3F800000, opAdd);
        sendOp(32'h41200000, 32'h3DCCCCCD, opAdd);
        sendOp(32'h7E000000, 32'h7E000000, opAdd);
        finishTest("normal addition", 1'b1);

        sendOp(32'h40400000, 32'h3F800000, opSub);
        sendOp(32'h3F800001, 32'h3F800000, opSub);
        sendOp(32'h3F800000, 32'h3F800000, opSub);
        sendOp(32'h80000000, 32'h80000000, opAdd);
        sendOp(32'hC0000000, 32'h3F800000, opAdd);
        sendOp(32'h3F800000, 32'hBF7FFFFF, opAdd);
        finishTest("subtraction and cancellation", 1'b1);

        // Exponent gaps of 1, 2, 25 and 30, plus ties at the guard bit
        sendOp(32'h3F800001, 32'h3F000001, opAdd);
        sendOp(32'h3F800001, 32'h3E800003, opAdd);
        sendOp(32'h3F800000, 32'h33000000, opAdd);
        sendOp(32'h3F800000, 32'h30800000, opAdd);
        sendOp(32'h3F800001, 32'h33800000, opAdd);
        sendOp(32'h3F800000, 32'h33800000, opAdd);
        sendOp(32'h3F800000, 32'h33000001, opSub);
        finishTest("rounding", 1'b1);

        sendOp(32'h7FC00001, 32'h3F800000, opAdd);
        sendOp(32'h3F800000, 32'hFF800001, opAdd);
        sendOp(32'h7F800000, 32'h7F800000, opSub);
        sendOp(32'h7F800000, 32'h3F800000, opAdd);
        sendOp(32'h42000000, 32'hFF800000, opAdd);
        sendOp(32'h00000001, 32'h3F800000, opAdd);
        sendOp(32'h807FFFFF, 32'h007FFFFF, opAdd);
        sendOp(32'h7F7FFFFF, 32'h7F7FFFFF, opAdd);
        sendOp(32'h00800001, 32'h00800000, opSub);
        finishTest("special values", 1'b1);

        for (int i = 0; i < 200; i++)
        begin
            a = $random(seed);
            b = $random(seed);
            opBits = $random(seed);
            // Every other pair gets close exponents so cancellation shows up
            if (i % 2 == 1)
                b[30:23] = a[30:23] ^ {6'b0, opBits[2:1]};
            sendOp(a, b, fpOp_t'(opBits[0]));
        end
        finishTest("random throughput", 1'b1);

        for (int i = 0; i < 6; i++)
            sendOp(32'h40000000 + i, 32'h3F800000, opAdd);
        @(negedge clock);
        reset = 1'b1;
        inValid = 1'b0;
        repeat (4) @(negedge clock);
        reset = 1'b0;
        sendOp(32'h40400000, 32'h3F800000, opSub);
        sendOp(32'h3F800000, 32'h3F800000, opAdd);
        sendOp(32'hC1200000, 32'h41200000, opAdd);
        finishTest("reset mid-stream", 1'b0);

        $display("Tests passed %0d, tests failed %0d, results checked %0d, assertion failures %0d",
                 testPass, testFail, checkCount, dut_i.checker_i.assertFails);
        if (testFail == 0 && failCount == 0 && dut_i.checker_i.assertFails == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

    // Watchdog in case the clocked sequence stalls
    initial
    begin
        #200000;
        $display("Simulation did not finish within the time limit");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+include
src/fpAddPkg.sv
src/alignment.sv
src/mantissaAdder.sv
src/normalizeRound.sv
src/fpAdder.sv
tests/fpAdder_checker.sv
tests/fpAdderMonitor.sv
tests/fpAdderTb.sv

//--- Bender.yml
package:
  name: fp_adder

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/fpAddPkg.sv
      - src/alignment.sv
      - src/mantissaAdder.sv
      - src/normalizeRound.sv
      - src/fpAdder.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/fpAdder_checker.sv
      - tests/fpAdderMonitor.sv
      - tests/fpAdderTb.sv
